/* compile.f */
verilog/flashPkg.sv
verilog/flashCmdLatch.sv
verilog/flashSckGen.sv
verilog/flashSequencer.sv
verilog/flashCore.sv
dv/flashClkGen.sv
dv/flashCoreTb.sv

/* dv/flashClkGen.sv */
`timescale 1ns/1ps

module flashClkGen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;      // 10 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

/* dv/flashCoreTb.sv */
`timescale 1ns/1ps

module flashCoreTb;
    import flashPkg::*;

    localparam int WAIT_LIMIT = 20000;

    logic       CLK_I;
    logic       RST_I;
    flashReq_t  req_i;
    logic       start_i;
    sckDiv_t    sckDiv_i;
    payload_t   rdData_o;
    logic       busy_o;
    logic       finish_o;
    logic       flashCs;
    logic       flashSck;
    logic       flashMosi;
    logic       flashMiso;

    // golden line fields
    logic [6:0]   cmdVal;
    flashAddr_t   addrVal;
    byteCount_t   byteNum;
    payload_t     wrData;
    sckDiv_t      divVal;
    payload_t     rdFlash;
    int           expBits;
    logic [63:0]  expSent;
    payload_t     expRd;

    // flash model state
    int           curBits;
    int           curRx;
    payload_t     curRd;
    int           csLowCnt;
    int           sckRises;
    int           sckFalls;
    logic [127:0] recBits;

    int           finishCnt;
    int           errors;
    int           lineNo;

    flashClkGen clkGen (.clk_o(CLK_I), .rst_o(RST_I));

    flashCore DUT (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .req_i       (req_i),
        .start_i     (start_i),
        .sckDiv_i    (sckDiv_i),
        .rdData_o    (rdData_o),
        .busy_o      (busy_o),
        .finish_o    (finish_o),
        .flashCs_o   (flashCs),
        .flashSck_o  (flashSck),
        .flashMosi_o (flashMosi),
        .flashMiso_i (flashMiso)
    );

    //////////////////////////////
    // flash model
    //////////////////////////////
    function automatic logic nextMisoBit(input int fallNum);
        int idx;
        idx = fallNum - curBits;                 // read bits follow the sent bits
        if (idx >= 0 && idx < curRx) begin
            return curRd[curRx - 1 - idx];
        end
        return 1'b0;
    endfunction

    always @(negedge flashCs) begin
        csLowCnt  = csLowCnt + 1;
        sckRises  = 0;
        sckFalls  = 0;
        recBits   = '0;
        flashMiso = 1'b0;
    end

    always @(posedge flashSck) begin
        if (!flashCs) begin
            recBits  = {recBits[126:0], flashMosi};
            sckRises = sckRises + 1;
        end
    end

    always @(negedge flashSck) begin
        if (!flashCs) begin
            sckFalls  = sckFalls + 1;
            flashMiso = nextMisoBit(sckFalls);   // ready for the next rise
        end
    end

    always @(negedge CLK_I) begin
        if (!RST_I && finish_o === 1'b1) begin
            finishCnt = finishCnt + 1;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic checkValue(input logic [127:0] got, input logic [127:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: line %0d %s, got %0h expected %0h",
                     $time, lineNo, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic pulseStart();
        @(negedge CLK_I);
        start_i = 1'b1;
        repeat (2) @(negedge CLK_I);
        start_i = 1'b0;
    endtask

    task automatic waitForBusy(output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge CLK_I);
            if (busy_o) seen = 1'b1;
            else n = n + 1;
        end
        if (!seen) begin
            $display("timeout: busy_o never rose on golden line %0d", lineNo);
            errors = errors + 1;
        end
    endtask

    task automatic waitForFinish(output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge CLK_I);
            if (finish_o) seen = 1'b1;
            else n = n + 1;
        end
        if (!seen) begin
            $display("timeout: finish_o did not pulse within %0d cycles on golden line %0d",
                     WAIT_LIMIT, lineNo);
            errors = errors + 1;
        end
    endtask

    task automatic runLine();
        int   csBefore;
        int   finBefore;
        int   rxBits;
        logic ok;
        rxBits = 0;
        if (cmdVal == CMD_READ) rxBits = 8 * int'(byteNum);
        else if (cmdVal == CMD_RFSR) rxBits = 8;
        curBits = expBits;
        curRx   = rxBits;
        curRd   = rdFlash;
        csBefore  = csLowCnt;
        finBefore = finishCnt;
        req_i.cmd     = cmdCode_t'(cmdVal);
        req_i.addr    = addrVal;
        req_i.byteNum = byteNum;
        req_i.wrData  = wrData;
        sckDiv_i      = divVal;
        pulseStart();
        if (expBits == 0) begin
            repeat (200) @(negedge CLK_I);       // illegal code, nothing may happen
            checkValue(csLowCnt - csBefore, 0, "CS activity for illegal command");
            checkValue(finishCnt - finBefore, 0, "finish_o for illegal command");
            checkValue(busy_o, 0, "busy_o for illegal command");
        end else begin
            waitForBusy(ok);
            if (ok) pulseStart();                // this edge must be dropped
            waitForFinish(ok);
            if (ok) begin
                checkValue(flashCs, 1, "CS at finish_o");
                checkValue(busy_o, 0, "busy_o at finish_o");
                checkValue(sckRises, expBits + rxBits, "SCK rise count");
                checkValue(sckFalls, expBits + rxBits, "SCK fall count");
                checkValue(recBits >> rxBits, expSent, "sent bit string");
                if (rxBits != 0) checkValue(rdData_o, expRd, "rdData_o");
                repeat (3) @(negedge CLK_I);
                checkValue(finish_o, 0, "finish_o after pulse");
                checkValue(busy_o, 0, "busy_o after finish_o");
                checkValue(csLowCnt - csBefore, 1, "CS low periods");
                checkValue(finishCnt - finBefore, 1, "finish_o pulses");
            end
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int    fd;
        int    nItems;
        int    n;
        string line;
        req_i     = '0;
        start_i   = 1'b0;
        sckDiv_i  = sckDiv_t'(2);
        flashMiso = 1'b0;
        csLowCnt  = 0;
        sckRises  = 0;
        sckFalls  = 0;
        recBits   = '0;
        curBits   = 0;
        curRx     = 0;
        curRd     = '0;
        finishCnt = 0;
        errors    = 0;
        lineNo    = 0;
        n = 0;
        @(negedge CLK_I);
        while (RST_I && n < WAIT_LIMIT) begin
            @(negedge CLK_I);
            n = n + 1;
        end
        if (RST_I) begin
            $display("timeout: reset never released");
            errors = errors + 1;
        end
        repeat (2) @(negedge CLK_I);
        checkValue(flashCs, 1, "CS after reset");
        checkValue(flashSck, 0, "SCK after reset");
        checkValue(flashMosi, 0, "MOSI after reset");
        checkValue(busy_o, 0, "busy_o after reset");
        checkValue(finish_o, 0, "finish_o after reset");
        checkValue(rdData_o, 0, "rdData_o after reset");
        fd = $fopen("dv/flashGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file dv/flashGolden.txt");
            errors = errors + 1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                nItems = $sscanf(line, "%h %h %h %h %h %h %d %h %h", cmdVal, addrVal,
                                 byteNum, wrData, divVal, rdFlash, expBits, expSent, expRd);
                lineNo = lineNo + 1;
                if (nItems != 9) begin
                    $display("golden line %0d is malformed", lineNo);
                    errors = errors + 1;
                end else begin
                    runLine();
                end
            end
            $fclose(fd);
            if (lineNo == 0) begin
                $display("golden file holds no transactions");
                errors = errors + 1;
            end
        end
        $display("run finished with %0d errors over %0d golden lines", errors, lineNo);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dv/flashGolden.txt */
# cmd addr byteNum wrData sckDiv flashReadData expBits(dec) expSentWord expRdData
# expBits 0 marks an illegal command that must start nothing
01 000000 0 00000000 002 00000000 8 0000000000000006 00000000
02 12ABCD 0 00000000 003 00000000 32 00000000D812ABCD 00000000
03 000000 0 00000000 008 00000000 8 00000000000000C7 00000000
07 001000 4 A1B2C3D4 002 00000000 64 02001000A1B2C3D4 00000000
07 3F0010 2 00005A3C 003 00000000 48 0000023F00105A3C 00000000
07 000100 1 000000E7 008 00000000 40 00000002000100E7 00000000
08 00ABCD 4 00000000 002 89ABCDEF 32 000000000300ABCD 89ABCDEF
08 765432 3 00000000 003 00C3A5F0 32 0000000003765432 00C3A5F0
08 000001 1 00000000 008 0000007E 32 0000000003000001 0000007E
09 000000 0 00000000 002 00000081 8 0000000000000070 00000081
09 000000 0 00000000 008 000000C5 8 0000000000000070 000000C5
05 000000 0 00000000 002 00000000 0 0000000000000000 00000000
0A 000000 2 0000FFFF 003 00000000 0 0000000000000000 00000000
01 000000 0 00000000 003 00000000 8 0000000000000006 00000000

/* run.sh */
#!/bin/sh
# build and run the flash controller testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert -f compile.f --top-module flashCoreTb -Mdir obj_dir -o simv \
    || { echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "^TB PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verilog/flashCmdLatch.sv */
`timescale 1ns/1ps

module flashCmdLatch (
    input  logic                CLK_I,
    input  logic                RST_I,
    input  logic                start_i,
    input  flashPkg::flashReq_t req_i,
    input  logic                busy_i,
    output flashPkg::flashJob_t job_o,
    output logic                jobValid_o
);
    import flashPkg::*;

    logic      startDly;
    logic      startEdge;
    logic      legalCmd;
    logic      accept;
    bitCount_t byteBits;
    flashJob_t jobNext;

    assign startEdge = start_i & ~startDly;            // low-to-high on start
    assign accept    = startEdge & ~busy_i & legalCmd;
    assign byteBits  = bitCount_t'(req_i.byteNum) << 3;

    always_comb begin
        jobNext.addr     = req_i.addr;
        jobNext.byteNum  = req_i.byteNum;
        jobNext.wrData   = req_i.wrData;
        jobNext.opcode   = OP_WREN;
        jobNext.sendAddr = 1'b0;
        jobNext.dataBits = '0;
        jobNext.isRead   = 1'b0;
        legalCmd         = 1'b1;
        case (req_i.cmd)
            CMD_WREN: begin
                jobNext.opcode = OP_WREN;
            end
            CMD_SE: begin
                jobNext.opcode   = OP_SE;
                jobNext.sendAddr = 1'b1;
            end
            CMD_BE: begin
                jobNext.opcode = OP_BE;
            end
            CMD_PP: begin
                jobNext.opcode   = OP_PP;
                jobNext.sendAddr = 1'b1;
                jobNext.dataBits = byteBits;
            end
            CMD_READ: begin
                jobNext.opcode   = OP_READ;
                jobNext.sendAddr = 1'b1;
                jobNext.dataBits = byteBits;
                jobNext.isRead   = 1'b1;
            end
            CMD_RFSR: begin
                jobNext.opcode   = OP_RFSR;
                jobNext.dataBits = bitCount_t'(8);        // one status byte
                jobNext.isRead   = 1'b1;
                jobNext.byteNum  = byteCount_t'(1);
            end
            default: begin
                legalCmd = 1'b0;                          // unknown code, no job
            end
        endcase
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            startDly   <= 1'b0;
            jobValid_o <= 1'b0;
        end else begin
            startDly   <= start_i;
            jobValid_o <= accept;
        end
    end

    always_ff @(posedge CLK_I) begin
        if (accept) begin
            job_o <= jobNext;
        end
    end

    // busy covers the handover cycle so a second edge there is dropped
    busyAtHandover: assert property (@(posedge CLK_I) disable iff (RST_I)
        jobValid_o |-> busy_i);

endmodule

/* verilog/flashCore.sv */
`timescale 1ns/1ps

module flashCore (
    input  logic                CLK_I,
    input  logic                RST_I,
    input  flashPkg::flashReq_t req_i,
    input  logic                start_i,
    input  flashPkg::sckDiv_t   sckDiv_i,
    output flashPkg::payload_t  rdData_o,
    output logic                busy_o,
    output logic                finish_o,
    output logic                flashCs_o,
    output logic                flashSck_o,
    output logic                flashMosi_o,
    input  logic                flashMiso_i
);
    import flashPkg::*;

    flashJob_t job;
    logic      jobValid;
    logic      sckRun;
    logic      sckRise;
    logic      sckFall;

    flashCmdLatch cmdLatch (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .start_i    (start_i),
        .req_i      (req_i),
        .busy_i     (busy_o),      // edges dropped while busy
        .job_o      (job),
        .jobValid_o (jobValid)
    );

    flashSequencer sequencer (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .job_i       (job),
        .jobValid_i  (jobValid),
        .sckRise_i   (sckRise),
        .sckFall_i   (sckFall),
        .flashMiso_i (flashMiso_i),
        .sckRun_o    (sckRun),
        .flashCs_o   (flashCs_o),
        .flashMosi_o (flashMosi_o),
        .busy_o      (busy_o),
        .finish_o    (finish_o),
        .rdData_o    (rdData_o)
    );

    flashSckGen sckGen (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .sckRun_i   (sckRun),
        .sckDiv_i   (sckDiv_i),
        .sckRise_o  (sckRise),
        .sckFall_o  (sckFall),
        .flashSck_o (flashSck_o)
    );

endmodule

/* verilog/flashPkg.sv */
package flashPkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int MAX_BYTES     = 4;
    localparam int ADDR_BITS     = 24;
    localparam int OPCODE_BITS   = 8;
    localparam int CMD_BITS      = 7;
    localparam int SCK_DIV_BITS  = 10;
    localparam int PAYLOAD_BITS  = 8 * MAX_BYTES;
    localparam int BYTE_CNT_BITS = $clog2(MAX_BYTES + 1);    // 0 .. MAX_BYTES
    localparam int BIT_CNT_BITS  = $clog2(PAYLOAD_BITS + 1); // covers address and payload

    //////////////////////////////
    // guard delays, system clocks
    //////////////////////////////
    localparam int CS_SETUP_CYCLES  = 20;
    localparam int CS_HOLD_CYCLES   = 20;
    localparam int BUSY_HOLD_CYCLES = 20;
    localparam int GUARD_A   = (CS_SETUP_CYCLES > CS_HOLD_CYCLES) ? CS_SETUP_CYCLES
                                                                  : CS_HOLD_CYCLES;
    localparam int MAX_GUARD = (GUARD_A > BUSY_HOLD_CYCLES) ? GUARD_A : BUSY_HOLD_CYCLES;
    localparam int DELAY_BITS = $clog2(MAX_GUARD + 1);

    typedef logic [BYTE_CNT_BITS-1:0] byteCount_t;
    typedef logic [PAYLOAD_BITS-1:0]  payload_t;
    typedef logic [ADDR_BITS-1:0]     flashAddr_t;
    typedef logic [OPCODE_BITS-1:0]   opcode_t;
    typedef logic [SCK_DIV_BITS-1:0]  sckDiv_t;
    typedef logic [BIT_CNT_BITS-1:0]  bitCount_t;
    typedef logic [DELAY_BITS-1:0]    delayCount_t;

    // core command codes seen on req_i
    typedef enum logic [CMD_BITS-1:0] {
        CMD_WREN = 7'd1,
        CMD_SE   = 7'd2,
        CMD_BE   = 7'd3,
        CMD_PP   = 7'd7,
        CMD_READ = 7'd8,
        CMD_RFSR = 7'd9
    } cmdCode_t;

    // flash instruction bytes
    localparam opcode_t OP_WREN = 8'h06;
    localparam opcode_t OP_SE   = 8'hD8;
    localparam opcode_t OP_BE   = 8'hC7;
    localparam opcode_t OP_PP   = 8'h02;
    localparam opcode_t OP_READ = 8'h03;
    localparam opcode_t OP_RFSR = 8'h70;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CS_SETUP,
        ST_OPCODE,
        ST_ADDR,
        ST_WRITE,
        ST_RD_LEAD,
        ST_READ,
        ST_CLK_STOP,
        ST_CS_HOLD,
        ST_BUSY_HOLD
    } seqState_t;

    typedef struct packed {
        cmdCode_t   cmd;
        flashAddr_t addr;
        byteCount_t byteNum;
        payload_t   wrData;
    } flashReq_t;

    typedef struct packed {
        opcode_t    opcode;
        flashAddr_t addr;
        logic       sendAddr;   // 24 address bits follow the opcode
        bitCount_t  dataBits;   // data bits after opcode/address
        logic       isRead;
        byteCount_t byteNum;
        payload_t   wrData;
    } flashJob_t;

endpackage

/* verilog/flashSckGen.sv */
`timescale 1ns/1ps

module flashSckGen (
    input  logic              CLK_I,
    input  logic              RST_I,
    input  logic              sckRun_i,
    input  flashPkg::sckDiv_t sckDiv_i,
    output logic              sckRise_o,
    output logic              sckFall_o,
    output logic              flashSck_o
);
    import flashPkg::*;

    sckDiv_t               riseCnt;     // cycles to next rise
    sckDiv_t               halfDiv;
    logic [SCK_DIV_BITS:0] fallCnt;     // first lap spans 1.5 periods
    logic [SCK_DIV_BITS:0] firstFall;
    logic [SCK_DIV_BITS:0] fallReload;

    assign halfDiv    = sckDiv_i >> 1;
    assign firstFall  = {1'b0, sckDiv_i} + {1'b0, halfDiv};
    assign fallReload = {1'b0, sckDiv_i} - 1'b1;

    // strobes die the cycle sckRun drops
    assign sckRise_o = sckRun_i & (riseCnt == '0);
    assign sckFall_o = sckRun_i & (fallCnt == '0);

    //////////////////////////////
    // phase counters
    //////////////////////////////
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            riseCnt <= '0;
            fallCnt <= '0;
        end else if (!sckRun_i) begin
            riseCnt <= sckDiv_i;                    // restart while stopped
            fallCnt <= firstFall;
        end else begin
            if (sckRise_o) begin
                riseCnt <= sckDiv_i - 1'b1;
            end else begin
                riseCnt <= riseCnt - 1'b1;
            end
            if (sckFall_o) begin
                fallCnt <= fallReload;
            end else begin
                fallCnt <= fallCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            flashSck_o <= 1'b0;
        end else if (sckRise_o) begin
            flashSck_o <= 1'b1;
        end else if (sckFall_o) begin
            flashSck_o <= 1'b0;
        end
    end

    // divider below 2 has no room for a half period
    divLegal: assert property (@(posedge CLK_I) disable iff (RST_I)
        sckRun_i |-> (sckDiv_i >= sckDiv_t'(2)));

endmodule

/* verilog/flashSequencer.sv */
`timescale 1ns/1ps

module flashSequencer (
    input  logic                CLK_I,
    input  logic                RST_I,
    input  flashPkg::flashJob_t job_i,
    input  logic                jobValid_i,
    input  logic                sckRise_i,
    input  logic                sckFall_i,
    input  logic                flashMiso_i,
    output logic                sckRun_o,
    output logic                flashCs_o,
    output logic                flashMosi_o,
    output logic                busy_o,
    output logic                finish_o,
    output flashPkg::payload_t  rdData_o
);
    import flashPkg::*;

    seqState_t   state;
    delayCount_t delayCnt;
    bitCount_t   bitCnt;      // bits still to move in this phase
    opcode_t     opShift;
    flashAddr_t  addrShift;
    payload_t    dataShift;   // write data out, read data in
    bitCount_t   dataBits;
    logic        sendAddr;
    logic        isRead;
    bitCount_t   alignShift;
    payload_t    wrAligned;
    payload_t    rdNext;

    // left-justify so byte byteNum-1 goes out first
    assign alignShift = bitCount_t'(byteCount_t'(MAX_BYTES) - job_i.byteNum) << 3;
    assign wrAligned  = job_i.wrData << alignShift;
    assign rdNext     = {dataShift[PAYLOAD_BITS-2:0], flashMiso_i};

    assign busy_o = jobValid_i | (state != ST_IDLE);

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state       <= ST_IDLE;
            delayCnt    <= '0;
            bitCnt      <= '0;
            sckRun_o    <= 1'b0;
            flashCs_o   <= 1'b1;
            flashMosi_o <= 1'b0;
            finish_o    <= 1'b0;
            rdData_o    <= '0;
        end else begin
            finish_o <= 1'b0;
            case (state)
                //////////////////////////////
                // start and CS setup
                //////////////////////////////
                ST_IDLE: begin
                    if (jobValid_i) begin
                        opShift     <= job_i.opcode << 1;
                        addrShift   <= job_i.addr;
                        dataShift   <= job_i.isRead ? '0 : wrAligned;
                        dataBits    <= job_i.dataBits;
                        sendAddr    <= job_i.sendAddr;
                        isRead      <= job_i.isRead;
                        flashCs_o   <= 1'b0;
                        flashMosi_o <= job_i.opcode[OPCODE_BITS-1]; // first bit with CS
                        bitCnt      <= bitCount_t'(OPCODE_BITS - 1);
                        delayCnt    <= delayCount_t'(CS_SETUP_CYCLES - 1);
                        state       <= ST_CS_SETUP;
                    end
                end
                ST_CS_SETUP: begin
                    if (delayCnt == '0) begin
                        sckRun_o <= 1'b1;
                        state    <= ST_OPCODE;
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                //////////////////////////////
                // outgoing bits, on sckFall
                //////////////////////////////
                ST_OPCODE: begin
                    if (sckFall_i) begin
                        flashMosi_o <= opShift[OPCODE_BITS-1];
                        opShift     <= opShift << 1;
                        if (bitCnt == bitCount_t'(1)) begin
                            if (sendAddr) begin
                                bitCnt <= bitCount_t'(ADDR_BITS);
                                state  <= ST_ADDR;
                            end else if (isRead) begin
                                bitCnt <= dataBits;     // RFSR
                                state  <= ST_RD_LEAD;
                            end else begin
                                state <= ST_CLK_STOP;   // WREN, BE
                            end
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                end
                ST_ADDR: begin
                    if (sckFall_i) begin
                        flashMosi_o <= addrShift[ADDR_BITS-1];
                        addrShift   <= addrShift << 1;
                        if (bitCnt == bitCount_t'(1)) begin
                            bitCnt <= dataBits;
                            if (isRead) begin
                                state <= ST_RD_LEAD;
                            end else if (dataBits != '0) begin
                                state <= ST_WRITE;
                            end else begin
                                state <= ST_CLK_STOP;   // SE
                            end
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                end
                ST_WRITE: begin
                    if (sckFall_i) begin
                        flashMosi_o <= dataShift[PAYLOAD_BITS-1];
                        dataShift   <= dataShift << 1;
                        if (bitCnt == bitCount_t'(1)) begin
                            state <= ST_CLK_STOP;
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                end
                //////////////////////////////
                // incoming bits, on sckRise
                //////////////////////////////
                ST_RD_LEAD: begin
                    // this rise still samples the last sent bit
                    if (sckRise_i) begin
                        state <= (bitCnt == '0) ? ST_CLK_STOP : ST_READ;
                    end
                end
                ST_READ: begin
                    if (sckRise_i) begin
                        dataShift <= rdNext;
                        if (bitCnt == bitCount_t'(1)) begin
                            rdData_o <= rdNext;         // right-aligned result
                            state    <= ST_CLK_STOP;
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                end
                //////////////////////////////
                // close out
                //////////////////////////////
                ST_CLK_STOP: begin
                    // closing fall brings SCK back low
                    if (sckFall_i) begin
                        sckRun_o    <= 1'b0;
                        flashMosi_o <= 1'b0;
                        delayCnt    <= delayCount_t'(CS_HOLD_CYCLES - 1);
                        state       <= ST_CS_HOLD;
                    end
                end
                ST_CS_HOLD: begin
                    if (delayCnt == '0) begin
                        flashCs_o <= 1'b1;
                        delayCnt  <= delayCount_t'(BUSY_HOLD_CYCLES - 1);
                        state     <= ST_BUSY_HOLD;
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                ST_BUSY_HOLD: begin
                    if (delayCnt == '0) begin
                        finish_o <= 1'b1;               // busy_o drops with it
                        state    <= ST_IDLE;
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // chip select only asserted inside a transaction
    csInBusy: assert property (@(posedge CLK_I) disable iff (RST_I)
        !flashCs_o |-> busy_o);

    finishPulse: assert property (@(posedge CLK_I) disable iff (RST_I)
        finish_o |=> !finish_o);

endmodule
